//--- Bender.yml
package:
  name: simd_exec

sources:
  # Design, package and interface first
  - src/expipe_pkg.sv
  - src/eu_if.sv
  - src/generic_rs.sv
  - src/simd_eu.sv
  - src/simd_exec_top.sv
  # Testbench with its model header
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_simd_exec.sv

//--- dv/simd_model.svh
// Reference model for lane arithmetic, unsigned divide and exception codes, plus the LFSR step
`ifndef SIMD_MODEL_SVH
`define SIMD_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// Per-lane add, subtract or unsigned max, each lane masked so no carry leaks
function automatic logic [63:0] model_lanes(input logic [1:0] op, input logic [1:0] w,
                                            input logic [63:0] a, input logic [63:0] b);
    int          lw;
    logic [63:0] mask;
    logic [63:0] la;
    logic [63:0] lb;
    logic [63:0] lr;
    logic [63:0] res;
    lw   = 8 << w;
    mask = (lw == 64) ? '1 : ((64'd1 << lw) - 64'd1);
    res  = '0;
    for (int i = 0; i < 64 / lw; i++) begin
        la = (a >> (i * lw)) & mask;
        lb = (b >> (i * lw)) & mask;
        case (op)
            expipe_pkg::OP_ADD: lr = la + lb;
            expipe_pkg::OP_SUB: lr = la - lb;
            default:            lr = (la > lb) ? la : lb;
        endcase
        res = res | ((lr & mask) << (i * lw));
    end
    return res;
endfunction

// Exception code, bad width is reported before a zero divisor
function automatic logic [1:0] model_code(input logic [3:0] ctl, input logic [63:0] b);
    if (ctl[3:2] != expipe_pkg::OP_DIVU) begin
        return expipe_pkg::EXC_NONE;
    end
    if (ctl[1:0] != expipe_pkg::W64) begin
        return expipe_pkg::EXC_ILLEGAL;
    end
    if (b == '0) begin
        return expipe_pkg::EXC_DIV_ZERO;
    end
    return expipe_pkg::EXC_NONE;
endfunction

// Expected result word, zero for any faulting divide
function automatic logic [63:0] model_data(input logic [3:0] ctl, input logic [63:0] a,
                                           input logic [63:0] b);
    if (ctl[3:2] == expipe_pkg::OP_DIVU) begin
        if (model_code(ctl, b) != expipe_pkg::EXC_NONE) begin
            return '0;
        end
        return a / b;
    end
    return model_lanes(ctl[3:2], ctl[1:0], a, b);
endfunction

`endif

//--- dv/tb_simd_exec.sv
// Testbench for the execution slice with random operations, a tag scoreboard and a watchdog
`timescale 1ns/100ps

module tb_simd_exec;

    localparam int RS_DEPTH  = 8;
    localparam int TAG_W     = $clog2(RS_DEPTH);
    localparam int HALF      = 10;
    localparam int QTR       = 5;
    localparam int N_MIX     = 300;
    localparam int N_BP      = 40;
    localparam int N_FLUSH   = 6;
    localparam int N_POST    = 30;
    localparam int NUM_OPS   = N_MIX + N_BP + N_FLUSH + N_POST;
    localparam int WD_CYCLES = NUM_OPS * 80 + 500;

    logic               clk_i;
    logic               rst_n_i;
    logic               flush_i;
    logic               ins_valid_i;
    logic               ins_ready_o;
    logic [3:0]         ins_ctl_i;
    logic [63:0]        ins_rs1_i;
    logic [63:0]        ins_rs2_i;
    logic [TAG_W-1:0]   ins_tag_o;
    logic               res_valid_o;
    logic               res_ready_i;
    logic [TAG_W-1:0]   res_tag_o;
    logic [63:0]        res_data_o;
    logic               res_except_raised_o;
    logic [1:0]         res_except_code_o;

    // Scoreboard indexed by tag
    bit                 pending   [RS_DEPTH];
    logic [63:0]        exp_data  [RS_DEPTH];
    logic [1:0]         exp_code  [RS_DEPTH];
    int                 pending_cnt;

    // Last sampled commit that was held back
    bit                 held_valid;
    logic [TAG_W-1:0]   held_tag;
    logic [63:0]        held_data;
    logic               held_raised;
    logic [1:0]         held_code;

    logic [31:0]        lfsr_q;
    bit                 ins_fired;
    bit                 saw_full;
    int                 burst_left;
    int unsigned        err_value;
    int unsigned        err_proto;
    int unsigned        inserts;
    int unsigned        commits;

    `include "simd_model.svh"

    simd_exec_top #(
        .RS_DEPTH (RS_DEPTH)
    ) simd_exec_top_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .ins_valid_i         (ins_valid_i),
        .ins_ready_o         (ins_ready_o),
        .ins_ctl_i           (ins_ctl_i),
        .ins_rs1_i           (ins_rs1_i),
        .ins_rs2_i           (ins_rs2_i),
        .ins_tag_o           (ins_tag_o),
        .res_valid_o         (res_valid_o),
        .res_ready_i         (res_ready_i),
        .res_tag_o           (res_tag_o),
        .res_data_o          (res_data_o),
        .res_except_raised_o (res_except_raised_o),
        .res_except_code_o   (res_except_code_o)
    );

    always #(HALF) clk_i = ~clk_i;

    // Take n bits, one LFSR step per bit
    function automatic logic [63:0] draw(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!pending[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic value_error(input string msg);
        err_value++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic protocol_error(input string msg);
        err_proto++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Random operation, divides get mostly W64, shrunk divisors and some zero divisors
    task automatic new_op(input bit allow_div);
        logic [1:0]  op;
        logic [1:0]  w;
        logic [63:0] a;
        logic [63:0] b;
        op = draw(2);
        w  = draw(2);
        a  = draw(64);
        b  = draw(64);
        if (op == expipe_pkg::OP_DIVU) begin
            if (!allow_div) begin
                op = expipe_pkg::OP_ADD;
            end else begin
                if (draw(2) != 0) begin
                    w = expipe_pkg::W64;
                end
                b = b >> draw(6);
                if (draw(3) == 0) begin
                    b = '0;
                end
            end
        end
        ins_ctl_i = {op, w};
        ins_rs1_i = a;
        ins_rs2_i = b;
    endtask

    // Mode 0 random, mode 1 long low bursts, mode 2 held low
    task automatic drive_ready(input int mode);
        if (mode == 0) begin
            res_ready_i = (draw(2) != 0);
        end else if (mode == 2) begin
            res_ready_i = 1'b0;
        end else if (burst_left == 0) begin
            res_ready_i = !res_ready_i;
            burst_left  = res_ready_i ? 1 + int'(draw(3)) : 40 + int'(draw(5));
        end else begin
            burst_left--;
        end
    endtask

    // Insert n operations, valid held until accepted, random gaps between them
    task automatic run_ops(input int n_ops, input int mode, input bit allow_div);
        int sent;
        sent = 0;
        while (sent < n_ops) begin
            @(negedge clk_i);
            if (ins_valid_i && ins_fired) begin
                sent++;
                ins_valid_i = 1'b0;
            end
            if (!ins_valid_i && sent < n_ops && draw(2) != 0) begin
                new_op(allow_div);
                ins_valid_i = 1'b1;
            end
            drive_ready(mode);
        end
    endtask

    // Let every operation in flight commit
    task automatic drain();
        res_ready_i = 1'b1;
        while (pending_cnt != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic discard_pending();
        for (int i = 0; i < RS_DEPTH; i++) begin
            pending[i] = 1'b0;
        end
        pending_cnt = 0;
        held_valid  = 1'b0;
        ins_fired   = 1'b0;
    endtask

    // A held commit keeps its tag and its data until it is taken
    task automatic check_held();
        if (held_valid) begin
            if (!res_valid_o) begin
                protocol_error("res_valid_o dropped while a commit was held");
            end else if (res_tag_o != held_tag) begin
                protocol_error($sformatf("held tag %0d replaced by tag %0d",
                                         held_tag, res_tag_o));
            end else if (res_data_o !== held_data || res_except_code_o !== held_code
                         || res_except_raised_o !== held_raised) begin
                value_error($sformatf("held result for tag %0d changed", held_tag));
            end
        end
        held_valid  = res_valid_o && !res_ready_i;
        held_tag    = res_tag_o;
        held_data   = res_data_o;
        held_raised = res_except_raised_o;
        held_code   = res_except_code_o;
    endtask

    task automatic check_commit();
        int t;
        t = res_tag_o;
        if (!pending[t]) begin
            protocol_error($sformatf("commit of tag %0d that is not in flight", t));
        end else begin
            if (res_data_o !== exp_data[t]) begin
                value_error($sformatf("tag %0d data %h, expected %h", t, res_data_o, exp_data[t]));
            end
            if (res_except_code_o !== exp_code[t]) begin
                value_error($sformatf("tag %0d code %0d, expected %0d", t, res_except_code_o,
                                      exp_code[t]));
            end
            if (res_except_raised_o !== (exp_code[t] != expipe_pkg::EXC_NONE)) begin
                value_error($sformatf("tag %0d raised flag %b wrong", t, res_except_raised_o));
            end
            pending[t] = 1'b0;
            pending_cnt--;
        end
        commits++;
    endtask

    task automatic record_insert();
        int t;
        t = ins_tag_o;
        if (pending[t]) begin
            protocol_error($sformatf("insert reused tag %0d still in flight", t));
        end
        exp_data[t] = model_data(ins_ctl_i, ins_rs1_i, ins_rs2_i);
        exp_code[t] = model_code(ins_ctl_i, ins_rs2_i);
        pending[t]  = 1'b1;
        pending_cnt++;
        inserts++;
        ins_fired = 1'b1;
    endtask

    // Sample a quarter period before the rising edge, inputs and outputs settled
    always @(negedge clk_i) begin
        #(QTR);
        if (!rst_n_i) begin
            if (res_valid_o) begin
                protocol_error("res_valid_o high during reset");
            end
            ins_fired = 1'b0;
        end else if (flush_i) begin
            discard_pending();
        end else begin
            check_held();
            // Ready tracks occupancy, tag is the lowest free entry
            if (ins_ready_o != (pending_cnt < RS_DEPTH)) begin
                protocol_error($sformatf("ins_ready_o %b with %0d entries in use",
                                         ins_ready_o, pending_cnt));
            end
            if (ins_ready_o && ins_tag_o != TAG_W'(lowest_free())) begin
                protocol_error($sformatf("ins_tag_o %0d, expected %0d", ins_tag_o, lowest_free()));
            end
            if (pending_cnt == RS_DEPTH && !ins_ready_o) begin
                saw_full = 1'b1;
            end
            if (res_valid_o && pending_cnt == 0) begin
                protocol_error("res_valid_o high with nothing in flight");
            end
            if (res_valid_o && res_ready_i) begin
                check_commit();
            end
            if (ins_valid_i && ins_ready_o) begin
                record_insert();
            end else begin
                ins_fired = 1'b0;
            end
        end
    end

    // Watchdog sized from the operation count
    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Timeout: run did not finish, %0d value errors, %0d protocol errors",
                 err_value, err_proto);
        $display("Something failed");
        $finish;
    end

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        ins_valid_i = 1'b0;
        ins_ctl_i   = '0;
        ins_rs1_i   = '0;
        ins_rs2_i   = '0;
        res_ready_i = 1'b0;
        lfsr_q      = 32'd97345;
        burst_left  = 0;
        saw_full    = 1'b0;
        err_value   = 0;
        err_proto   = 0;
        inserts     = 0;
        commits     = 0;
        discard_pending();

        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        #(QTR);
        if (!ins_ready_o || ins_tag_o != '0) begin
            protocol_error("ins_ready_o or ins_tag_o wrong after reset");
        end

        // Mixed lane ops and divides
        run_ops(N_MIX, 0, 1'b1);
        // Back-pressure with short ops so the station fills
        run_ops(N_BP, 1, 1'b0);
        // Empty the station so the flush batch fits with commits blocked
        drain();
        // Fill part way with commits blocked, then flush
        run_ops(N_FLUSH, 2, 1'b1);
        @(negedge clk_i);
        flush_i     = 1'b1;
        ins_valid_i = 1'b0;
        @(negedge clk_i);
        flush_i     = 1'b0;
        res_ready_i = 1'b1;
        repeat (10) @(negedge clk_i);
        run_ops(N_POST, 0, 1'b1);

        // Drain everything still in flight
        drain();
        repeat (5) @(negedge clk_i);

        if (!saw_full) begin
            err_proto++;
            $display("Back-pressure never filled all entries of the station");
        end
        $display("Run done: %0d inserts, %0d commits, %0d value errors, %0d protocol errors",
                 inserts, commits, err_value, err_proto);
        if (err_value == 0 && err_proto == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src/eu_if.sv
// Station to execution unit link carrying the issue and write-back handshakes
`timescale 1ns/100ps

interface eu_if #(
    parameter int RS_DEPTH = 8
) ();

    localparam int TAG_W = $clog2(RS_DEPTH);

    // Issue channel, station to unit
    logic                                 iss_valid;
    logic                                 iss_ready;
    logic [expipe_pkg::EU_CTL_LEN-1:0]    iss_ctl;
    logic [expipe_pkg::XLEN-1:0]          iss_rs1;
    logic [expipe_pkg::XLEN-1:0]          iss_rs2;
    logic [TAG_W-1:0]                     iss_tag;

    // Write-back channel, unit to station
    logic                                 wb_valid;
    logic                                 wb_ready;
    logic [TAG_W-1:0]                     wb_tag;
    logic [expipe_pkg::XLEN-1:0]          wb_data;
    logic                                 wb_except_raised;
    logic [expipe_pkg::EXCEPT_LEN-1:0]    wb_except_code;

    // Station side
    modport rs (
        output iss_valid, iss_ctl, iss_rs1, iss_rs2, iss_tag,
        input  iss_ready,
        input  wb_valid, wb_tag, wb_data, wb_except_raised, wb_except_code,
        output wb_ready
    );

    // Unit side
    modport eu (
        input  iss_valid, iss_ctl, iss_rs1, iss_rs2, iss_tag,
        output iss_ready,
        output wb_valid, wb_tag, wb_data, wb_except_raised, wb_except_code,
        input  wb_ready
    );

endinterface

//--- src/expipe_pkg.sv
// Execution slice package with word width, operation and exception codes, SIMD lane view
package expipe_pkg;

    // Data word width, fixed because the lane view below is 64 bits wide
    localparam int XLEN = 64;

    // Control field: operation in the upper two bits, lane width in the lower two
    localparam int EU_CTL_LEN = 4;

    // Exception code width
    localparam int EXCEPT_LEN = 2;

    // Operation selector
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MAXU = 2'd2,
        OP_DIVU = 2'd3
    } eu_op_e;

    // Lane width selector
    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W32 = 2'd2,
        W64 = 2'd3
    } lane_w_e;

    // Exception codes reported with a result
    typedef enum logic [EXCEPT_LEN-1:0] {
        EXC_NONE     = 2'd0,
        EXC_DIV_ZERO = 2'd1,
        EXC_ILLEGAL  = 2'd2
    } except_e;

    // One operand word seen as bytes, halfwords, words or a doubleword
    typedef union packed {
        logic [7:0][7:0]  b8;
        logic [3:0][15:0] h16;
        logic [1:0][31:0] w32;
        logic [XLEN-1:0]  d64;
    } simd_word_u;

endpackage

//--- src/generic_rs.sv
// Reservation station holding tagged operations, dispatching to the unit and committing results
`timescale 1ns/100ps

module generic_rs #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,

    // Insert path
    input  logic                                 ins_valid_i,
    output logic                                 ins_ready_o,
    input  logic [expipe_pkg::EU_CTL_LEN-1:0]    ins_ctl_i,
    input  logic [expipe_pkg::XLEN-1:0]          ins_rs1_i,
    input  logic [expipe_pkg::XLEN-1:0]          ins_rs2_i,
    output logic [$clog2(RS_DEPTH)-1:0]          ins_tag_o,

    // Commit path
    output logic                                 res_valid_o,
    input  logic                                 res_ready_i,
    output logic [$clog2(RS_DEPTH)-1:0]          res_tag_o,
    output logic [expipe_pkg::XLEN-1:0]          res_data_o,
    output logic                                 res_except_raised_o,
    output logic [expipe_pkg::EXCEPT_LEN-1:0]    res_except_code_o,

    // Execution unit
    eu_if.rs                                     eu
);

    localparam int TAG_W = $clog2(RS_DEPTH);

    // Entry states
    localparam logic [1:0] ST_EMPTY = 2'd0;
    localparam logic [1:0] ST_READY = 2'd1;
    localparam logic [1:0] ST_EXEC  = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // Per-entry control state
    logic [1:0]                              state_q      [RS_DEPTH];

    // Per-entry operation and result payload
    logic [expipe_pkg::EU_CTL_LEN-1:0]       ctl_q        [RS_DEPTH];
    logic [expipe_pkg::XLEN-1:0]             rs1_q        [RS_DEPTH];
    logic [expipe_pkg::XLEN-1:0]             rs2_q        [RS_DEPTH];
    logic [expipe_pkg::XLEN-1:0]             res_q        [RS_DEPTH];
    logic                                    exc_raised_q [RS_DEPTH];
    logic [expipe_pkg::EXCEPT_LEN-1:0]       exc_code_q   [RS_DEPTH];

    // Priority scan results
    logic                                    free_found;
    logic                                    rdy_found;
    logic                                    done_found;
    logic [TAG_W-1:0]                        free_idx;
    logic [TAG_W-1:0]                        rdy_idx;
    logic [TAG_W-1:0]                        done_idx;
    logic [RS_DEPTH-1:0]                     exec_vec;

    // Handshake strobes
    logic                                    ins_fire;
    logic                                    iss_fire;
    logic                                    wb_fire;
    logic                                    res_fire;

    // Offered commit is locked while the consumer stalls
    logic                                    hold_q;
    logic [TAG_W-1:0]                        hold_idx_q;
    logic [TAG_W-1:0]                        cmt_idx;

    // Lowest index wins, so scan from the top down
    always_comb begin
        free_found = 1'b0;
        rdy_found  = 1'b0;
        done_found = 1'b0;
        free_idx   = '0;
        rdy_idx    = '0;
        done_idx   = '0;
        exec_vec   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == ST_EMPTY) begin
                free_found = 1'b1;
                free_idx   = TAG_W'(i);
            end
            if (state_q[i] == ST_READY) begin
                rdy_found = 1'b1;
                rdy_idx   = TAG_W'(i);
            end
            if (state_q[i] == ST_DONE) begin
                done_found = 1'b1;
                done_idx   = TAG_W'(i);
            end
            exec_vec[i] = (state_q[i] == ST_EXEC);
        end
    end

    // Nothing transfers on a flush cycle
    assign ins_ready_o = free_found && !flush_i;
    assign ins_tag_o   = free_idx;

    // Dispatch the oldest-index ready entry
    assign eu.iss_valid = rdy_found && !flush_i;
    assign eu.iss_tag   = rdy_idx;
    assign eu.iss_ctl   = ctl_q[rdy_idx];
    assign eu.iss_rs1   = rs1_q[rdy_idx];
    assign eu.iss_rs2   = rs2_q[rdy_idx];

    // Results are always taken unless flushing
    assign eu.wb_ready = !flush_i;

    // Commit port shows the lowest finished entry, kept until taken
    assign cmt_idx             = hold_q ? hold_idx_q : done_idx;
    assign res_valid_o         = done_found && !flush_i;
    assign res_tag_o           = cmt_idx;
    assign res_data_o          = res_q[cmt_idx];
    assign res_except_raised_o = exc_raised_q[cmt_idx];
    assign res_except_code_o   = exc_code_q[cmt_idx];

    assign ins_fire = ins_valid_i && ins_ready_o;
    assign iss_fire = eu.iss_valid && eu.iss_ready;
    assign wb_fire  = eu.wb_valid && eu.wb_ready;
    assign res_fire = res_valid_o && res_ready_i;

    // Stalled offer stays on the port even if a lower entry finishes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else if (flush_i || res_fire) begin
            hold_q <= 1'b0;
        end else if (res_valid_o) begin
            hold_q     <= 1'b1;
            hold_idx_q <= cmt_idx;
        end
    end

    // Entry state machines, each strobe hits an entry in a distinct state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= ST_EMPTY;
            end
        end else if (flush_i) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= ST_EMPTY;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (ins_fire && free_idx == TAG_W'(i)) begin
                    state_q[i] <= ST_READY;
                end
                if (iss_fire && rdy_idx == TAG_W'(i)) begin
                    state_q[i] <= ST_EXEC;
                end
                if (wb_fire && eu.wb_tag == TAG_W'(i)) begin
                    state_q[i] <= ST_DONE;
                end
                if (res_fire && cmt_idx == TAG_W'(i)) begin
                    state_q[i] <= ST_EMPTY;
                end
            end
        end
    end

    // Operand capture on insert, result capture on write-back
    always_ff @(posedge clk_i) begin
        if (ins_fire) begin
            ctl_q[free_idx] <= ins_ctl_i;
            rs1_q[free_idx] <= ins_rs1_i;
            rs2_q[free_idx] <= ins_rs2_i;
        end
        if (wb_fire) begin
            res_q[eu.wb_tag]        <= eu.wb_data;
            exc_raised_q[eu.wb_tag] <= eu.wb_except_raised;
            exc_code_q[eu.wb_tag]   <= eu.wb_except_code;
        end
    end

    // A result from the unit must belong to the entry that was dispatched
    a_wb_tag_exec: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eu.wb_valid |-> state_q[eu.wb_tag] == ST_EXEC);

    // The unit runs one operation at a time
    a_single_exec: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $countones(exec_vec) <= 1);

endmodule

//--- src/simd_eu.sv
// SIMD execution unit with single-cycle lane arithmetic and an iterative 64-bit divider
`timescale 1ns/100ps

module simd_eu (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    eu_if.eu     rs
);

    localparam int XLEN  = expipe_pkg::XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    // Decoded control
    expipe_pkg::eu_op_e      op;
    expipe_pkg::lane_w_e     lane_w;

    // Operand views and per-op lane results
    expipe_pkg::simd_word_u  opa_u;
    expipe_pkg::simd_word_u  opb_u;
    expipe_pkg::simd_word_u  sum_u;
    expipe_pkg::simd_word_u  diff_u;
    expipe_pkg::simd_word_u  max_u;

    // Single-cycle result
    logic [XLEN-1:0]                      fast_data;
    logic                                 fast_raised;
    logic [expipe_pkg::EXCEPT_LEN-1:0]    fast_code;

    // Divider state
    logic                                 div_busy_q;
    logic [CNT_W-1:0]                     cnt_q;
    logic [XLEN-1:0]                      quo_q;
    logic [XLEN-1:0]                      rem_q;
    logic [XLEN-1:0]                      dvsr_q;
    logic [XLEN:0]                        rem_shift;
    logic [XLEN:0]                        trial;
    logic                                 div_long;
    logic                                 div_last;
    logic                                 iss_fire;

    assign op     = expipe_pkg::eu_op_e'(rs.iss_ctl[expipe_pkg::EU_CTL_LEN-1 -: 2]);
    assign lane_w = expipe_pkg::lane_w_e'(rs.iss_ctl[1:0]);
    assign opa_u  = rs.iss_rs1;
    assign opb_u  = rs.iss_rs2;

    // Busy while dividing or while a result waits
    assign rs.iss_ready = !div_busy_q && !rs.wb_valid;
    assign iss_fire     = rs.iss_valid && rs.iss_ready;

    // Only a legal divide with a nonzero divisor iterates
    assign div_long = (op == expipe_pkg::OP_DIVU) && (lane_w == expipe_pkg::W64)
                      && (rs.iss_rs2 != '0);
    assign div_last = (cnt_q == CNT_W'(XLEN));

    // Lane-wise ops, each lane wraps on its own
    always_comb begin
        sum_u  = '0;
        diff_u = '0;
        max_u  = '0;
        unique case (lane_w)
            expipe_pkg::W8: begin
                for (int i = 0; i < 8; i++) begin
                    sum_u.b8[i]  = opa_u.b8[i] + opb_u.b8[i];
                    diff_u.b8[i] = opa_u.b8[i] - opb_u.b8[i];
                    max_u.b8[i]  = (opa_u.b8[i] > opb_u.b8[i]) ? opa_u.b8[i] : opb_u.b8[i];
                end
            end
            expipe_pkg::W16: begin
                for (int i = 0; i < 4; i++) begin
                    sum_u.h16[i]  = opa_u.h16[i] + opb_u.h16[i];
                    diff_u.h16[i] = opa_u.h16[i] - opb_u.h16[i];
                    max_u.h16[i]  = (opa_u.h16[i] > opb_u.h16[i]) ? opa_u.h16[i] : opb_u.h16[i];
                end
            end
            expipe_pkg::W32: begin
                for (int i = 0; i < 2; i++) begin
                    sum_u.w32[i]  = opa_u.w32[i] + opb_u.w32[i];
                    diff_u.w32[i] = opa_u.w32[i] - opb_u.w32[i];
                    max_u.w32[i]  = (opa_u.w32[i] > opb_u.w32[i]) ? opa_u.w32[i] : opb_u.w32[i];
                end
            end
            default: begin
                sum_u.d64  = opa_u.d64 + opb_u.d64;
                diff_u.d64 = opa_u.d64 - opb_u.d64;
                max_u.d64  = (opa_u.d64 > opb_u.d64) ? opa_u.d64 : opb_u.d64;
            end
        endcase
    end

    // Result for everything that finishes in one cycle
    always_comb begin
        fast_raised = 1'b0;
        fast_code   = expipe_pkg::EXC_NONE;
        unique case (op)
            expipe_pkg::OP_ADD:  fast_data = sum_u.d64;
            expipe_pkg::OP_SUB:  fast_data = diff_u.d64;
            expipe_pkg::OP_MAXU: fast_data = max_u.d64;
            default: begin
                // Short divide: bad width takes priority over a zero divisor
                fast_data   = '0;
                fast_raised = 1'b1;
                fast_code   = (lane_w != expipe_pkg::W64) ? expipe_pkg::EXC_ILLEGAL
                                                          : expipe_pkg::EXC_DIV_ZERO;
            end
        endcase
    end

    // Restoring step, shift in next dividend bit and try the subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvsr_q};

    // Control: divider sequencing and result valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_busy_q  <= 1'b0;
            cnt_q       <= '0;
            rs.wb_valid <= 1'b0;
        end else if (flush_i) begin
            div_busy_q  <= 1'b0;
            cnt_q       <= '0;
            rs.wb_valid <= 1'b0;
        end else begin
            if (rs.wb_valid && rs.wb_ready) begin
                rs.wb_valid <= 1'b0;
            end
            if (iss_fire) begin
                if (div_long) begin
                    div_busy_q <= 1'b1;
                    cnt_q      <= '0;
                end else begin
                    rs.wb_valid <= 1'b1;
                end
            end else if (div_busy_q) begin
                if (div_last) begin
                    div_busy_q  <= 1'b0;
                    rs.wb_valid <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // Datapath: operand latch, divider iteration, result registers
    always_ff @(posedge clk_i) begin
        if (iss_fire) begin
            rs.wb_tag <= rs.iss_tag;
            if (div_long) begin
                quo_q  <= rs.iss_rs1;
                rem_q  <= '0;
                dvsr_q <= rs.iss_rs2;
            end else begin
                rs.wb_data          <= fast_data;
                rs.wb_except_raised <= fast_raised;
                rs.wb_except_code   <= fast_code;
            end
        end else if (div_busy_q) begin
            if (div_last) begin
                rs.wb_data          <= quo_q;
                rs.wb_except_raised <= 1'b0;
                rs.wb_except_code   <= expipe_pkg::EXC_NONE;
            end else if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Held result must not change under back-pressure
    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rs.wb_valid && !rs.wb_ready |=> $stable(rs.wb_tag) && $stable(rs.wb_data));

endmodule

//--- src/simd_exec_top.sv
// Execution slice top joining the reservation station and the SIMD unit
`timescale 1ns/100ps

module simd_exec_top #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,

    // Insert path
    input  logic                                 ins_valid_i,
    output logic                                 ins_ready_o,
    input  logic [expipe_pkg::EU_CTL_LEN-1:0]    ins_ctl_i,
    input  logic [expipe_pkg::XLEN-1:0]          ins_rs1_i,
    input  logic [expipe_pkg::XLEN-1:0]          ins_rs2_i,
    output logic [$clog2(RS_DEPTH)-1:0]          ins_tag_o,

    // Commit path
    output logic                                 res_valid_o,
    input  logic                                 res_ready_i,
    output logic [$clog2(RS_DEPTH)-1:0]          res_tag_o,
    output logic [expipe_pkg::XLEN-1:0]          res_data_o,
    output logic                                 res_except_raised_o,
    output logic [expipe_pkg::EXCEPT_LEN-1:0]    res_except_code_o
);

    // Station to unit link
    eu_if #(
        .RS_DEPTH (RS_DEPTH)
    ) eu_if_i ();

    generic_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) generic_rs_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .ins_valid_i         (ins_valid_i),
        .ins_ready_o         (ins_ready_o),
        .ins_ctl_i           (ins_ctl_i),
        .ins_rs1_i           (ins_rs1_i),
        .ins_rs2_i           (ins_rs2_i),
        .ins_tag_o           (ins_tag_o),
        .res_valid_o         (res_valid_o),
        .res_ready_i         (res_ready_i),
        .res_tag_o           (res_tag_o),
        .res_data_o          (res_data_o),
        .res_except_raised_o (res_except_raised_o),
        .res_except_code_o   (res_except_code_o),
        .eu                  (eu_if_i.rs)
    );

    simd_eu simd_eu_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .rs      (eu_if_i.eu)
    );

endmodule

//--- verilog.f
+incdir+dv
src/expipe_pkg.sv
src/eu_if.sv
src/generic_rs.sv
src/simd_eu.sv
src/simd_exec_top.sv
dv/tb_simd_exec.sv
